/* verilog/pdp_rdma_reg_pkg.sv */
// pdp rdma register file shared definitions
// csb packet layouts, register map of the 4 KB window,
// status encodings and the launch parameter set of one group

package pdp_rdma_reg_pkg;

  ////////////////////////////////
  // widths
  ////////////////////////////////
  localparam int unsigned csb_addr_w   = 22;  // word address
  localparam int unsigned csb_data_w   = 32;
  localparam int unsigned reg_offset_w = 12;  // byte offset, 4 KB window
  localparam int unsigned dim_w        = 13;  // cube dimensions
  localparam int unsigned addr_field_w = 27;  // base address, line stride

  ////////////////////////////////
  // register map
  ////////////////////////////////
  // shared group
  localparam logic [reg_offset_w-1:0] reg_pointer_offs       = 12'h000; // producer b0, consumer b16
  localparam logic [reg_offset_w-1:0] reg_status_offs        = 12'h004; // read only
  // ping-pong groups, everything from here up
  localparam logic [reg_offset_w-1:0] group_base_offs        = 12'h008;
  localparam logic [reg_offset_w-1:0] op_enable_offs         = 12'h008;
  localparam logic [reg_offset_w-1:0] cube_in_width_offs     = 12'h00c;
  localparam logic [reg_offset_w-1:0] cube_in_height_offs    = 12'h010;
  localparam logic [reg_offset_w-1:0] cube_in_channel_offs   = 12'h014;
  localparam logic [reg_offset_w-1:0] src_base_addr_low_offs = 12'h018;
  localparam logic [reg_offset_w-1:0] src_line_stride_offs   = 12'h01c;

  // per-group status
  localparam logic [1:0] status_idle    = 2'd0;
  localparam logic [1:0] status_running = 2'd1;  // consumer on this group
  localparam logic [1:0] status_pending = 2'd2;  // armed, waiting its turn

  localparam int unsigned op_en_delay = 3;  // flops ahead of reg2dp_op_en

  // response kind bit
  localparam logic resp_id_read  = 1'b0;
  localparam logic resp_id_write = 1'b1;

  ////////////////////////////////
  // packets
  ////////////////////////////////
  // csb request, msb first: level at 62:61 down to addr at 21:0
  typedef struct packed {
    logic [1:0]            level;
    logic [3:0]            wrbe;
    logic                  srcpriv;
    logic                  nposted;
    logic                  write;
    logic [csb_data_w-1:0] wdat;
    logic [csb_addr_w-1:0] addr;
  } csb_req_t;

  typedef struct packed {
    logic                  kind;   // resp_id_read / resp_id_write
    logic                  error;
    logic [csb_data_w-1:0] rdat;
  } csb_resp_t;

  // one register access, valid the cycle after capture
  typedef struct packed {
    logic [reg_offset_w-1:0] offset;  // byte address
    logic [csb_data_w-1:0]   wr_data;
    logic                    wr_en;
    logic                    rd_en;
  } reg_access_t;

  typedef struct packed {
    logic [dim_w-1:0]        cube_in_width;
    logic [dim_w-1:0]        cube_in_height;
    logic [dim_w-1:0]        cube_in_channel;
    logic [addr_field_w-1:0] src_base_addr_low;
    logic [addr_field_w-1:0] src_line_stride;
  } rdma_cfg_t;

endpackage

/* verilog/csb_req_decode.sv */
// csb request decoder
// captures one request per cycle, presents it as a byte-addressed
// register access the next cycle and registers the csb response
// (read data, or an empty write ack for non-posted writes)

`timescale 1ns/1ps

module csb_req_decode import pdp_rdma_reg_pkg::*; (
  input  logic                  nvdla_core_clk,
  input  logic                  nvdla_core_rstn,
  input  logic                  req_pvld,
  input  csb_req_t              req_pd,
  input  logic [csb_data_w-1:0] rd_data,     // merged readback, same cycle
  output reg_access_t           access,
  output logic                  resp_valid,
  output csb_resp_t             resp_pd
);

  logic      req_pvld_q;
  csb_req_t  req_q;
  logic      wr_ack;      // non-posted write needs a response
  csb_resp_t resp_next;

  ////////////////////////////////
  // request capture
  ////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_pvld_q <= 1'b0;
    end else begin
      req_pvld_q <= req_pvld;
    end
  end

  // packet only loads with valid
  always_ff @(posedge nvdla_core_clk) begin
    if (req_pvld) begin
      req_q <= req_pd;
    end
  end

  ////////////////////////////////
  // register access
  ////////////////////////////////
  // word address to byte offset, only the 4 KB window matters
  assign access.offset  = {req_q.addr[reg_offset_w-3:0], 2'b00};
  assign access.wr_data = req_q.wdat;
  assign access.wr_en   = req_pvld_q & req_q.write;
  assign access.rd_en   = req_pvld_q & ~req_q.write;

  assign wr_ack = access.wr_en & req_q.nposted;

  ////////////////////////////////
  // response
  ////////////////////////////////
  always_comb begin
    resp_next = resp_pd;                  // hold when nothing to report
    if (access.rd_en) begin
      resp_next.kind  = resp_id_read;
      resp_next.error = 1'b0;
      resp_next.rdat  = rd_data;          // contents before this edge
    end else if (wr_ack) begin
      resp_next.kind  = resp_id_write;
      resp_next.error = 1'b0;
      resp_next.rdat  = '0;               // write ack carries no data
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      resp_valid <= 1'b0;
      resp_pd    <= '0;
    end else begin
      resp_valid <= access.rd_en | wr_ack;  // posted writes stay silent
      resp_pd    <= resp_next;
    end
  end

endmodule

/* verilog/rdma_reg_group.sv */
// ping-pong launch parameter group
// holds the five launch fields of one layer, decodes writes
// by offset, provides readback and flags op-enable writes

`timescale 1ns/1ps

module rdma_reg_group import pdp_rdma_reg_pkg::*; (
  input  logic                  nvdla_core_clk,
  input  logic                  nvdla_core_rstn,
  input  reg_access_t           access,
  input  logic                  wr_en,          // already qualified by select and op_en
  input  logic                  op_en,          // for readback only
  output rdma_cfg_t             cfg,
  output logic [csb_data_w-1:0] rd_data,
  output logic                  op_en_trigger
);

  ////////////////////////////////
  // field write
  ////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cfg <= '0;
    end else if (wr_en) begin
      case (access.offset)
        cube_in_width_offs: begin
          cfg.cube_in_width <= access.wr_data[dim_w-1:0];
        end
        cube_in_height_offs: begin
          cfg.cube_in_height <= access.wr_data[dim_w-1:0];
        end
        cube_in_channel_offs: begin
          cfg.cube_in_channel <= access.wr_data[dim_w-1:0];
        end
        src_base_addr_low_offs: begin
          cfg.src_base_addr_low <= access.wr_data[addr_field_w-1:0];
        end
        src_line_stride_offs: begin
          cfg.src_line_stride <= access.wr_data[addr_field_w-1:0];
        end
        default: begin
          // op_enable and unmapped offsets hold nothing here
        end
      endcase
    end
  end

  // op_en itself lives in the launch controller, flag the write
  assign op_en_trigger = wr_en & (access.offset == op_enable_offs);

  ////////////////////////////////
  // readback
  ////////////////////////////////
  always_comb begin
    rd_data = '0;                               // unmapped reads zero
    case (access.offset)
      op_enable_offs:         rd_data[0]                = op_en;
      cube_in_width_offs:     rd_data[dim_w-1:0]        = cfg.cube_in_width;
      cube_in_height_offs:    rd_data[dim_w-1:0]        = cfg.cube_in_height;
      cube_in_channel_offs:   rd_data[dim_w-1:0]        = cfg.cube_in_channel;
      src_base_addr_low_offs: rd_data[addr_field_w-1:0] = cfg.src_base_addr_low;
      src_line_stride_offs:   rd_data[addr_field_w-1:0] = cfg.src_line_stride;
      default:                rd_data                   = '0;
    endcase
  end

endmodule

/* verilog/rdma_launch_ctrl.sv */
// launch controller
// producer / consumer pointers and status of the shared group,
// per-group op_en, write qualification, read-data merge and
// selection of the parameter set that drives the datapath

`timescale 1ns/1ps

module rdma_launch_ctrl import pdp_rdma_reg_pkg::*; (
  input  logic                  nvdla_core_clk,
  input  logic                  nvdla_core_rstn,
  input  reg_access_t           access,
  input  logic                  done,              // layer complete
  input  rdma_cfg_t             d0_cfg,
  input  rdma_cfg_t             d1_cfg,
  input  logic [csb_data_w-1:0] d0_rd_data,
  input  logic [csb_data_w-1:0] d1_rd_data,
  input  logic                  d0_op_en_trigger,
  input  logic                  d1_op_en_trigger,
  output logic                  d0_wr_en,
  output logic                  d1_wr_en,
  output logic                  d0_op_en,
  output logic                  d1_op_en,
  output logic [csb_data_w-1:0] rd_data,
  output rdma_cfg_t             cfg,
  output logic                  op_en
);

  logic                   producer;
  logic                   consumer;
  logic [1:0]             grp_op_en;        // index = group
  logic [1:0]             grp_trigger;
  logic [1:0]             status [2];
  logic                   select_s;
  logic                   select_d0;
  logic                   select_d1;
  logic [csb_data_w-1:0]  s_rd_data;
  logic                   op_en_ori;        // op_en of consumer's group
  logic [op_en_delay-1:0] op_en_pipe;

  ////////////////////////////////
  // group select
  ////////////////////////////////
  assign select_s  = access.offset < group_base_offs;
  assign select_d0 = ~select_s & ~producer;
  assign select_d1 = ~select_s & producer;

  // armed groups are write protected
  assign d0_wr_en = access.wr_en & select_d0 & ~grp_op_en[0];
  assign d1_wr_en = access.wr_en & select_d1 & ~grp_op_en[1];

  ////////////////////////////////
  // pointers
  ////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      producer <= 1'b0;
      consumer <= 1'b0;
    end else begin
      if (access.wr_en && select_s && access.offset == reg_pointer_offs) begin
        producer <= access.wr_data[0];
      end
      if (done) begin
        consumer <= ~consumer;       // next layer, other group
      end
    end
  end

  ////////////////////////////////
  // op_en per group
  ////////////////////////////////
  assign grp_trigger = {d1_op_en_trigger, d0_op_en_trigger};

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      grp_op_en <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!grp_op_en[i] && grp_trigger[i]) begin
          grp_op_en[i] <= access.wr_data[0];
        end else if (done && consumer == i[0]) begin
          grp_op_en[i] <= 1'b0;      // layer of this group finished
        end
      end
    end
  end

  assign d0_op_en = grp_op_en[0];
  assign d1_op_en = grp_op_en[1];

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      status[i] = !grp_op_en[i]       ? status_idle    :
                  (consumer == i[0])  ? status_running :
                                        status_pending;
    end
  end

  ////////////////////////////////
  // readback merge
  ////////////////////////////////
  always_comb begin
    s_rd_data = '0;
    case (access.offset)
      reg_pointer_offs: begin
        s_rd_data[0]  = producer;
        s_rd_data[16] = consumer;
      end
      reg_status_offs: begin
        s_rd_data[1:0]   = status[0];
        s_rd_data[17:16] = status[1];
      end
      default: s_rd_data = '0;
    endcase
  end

  assign rd_data = ({csb_data_w{select_s}}  & s_rd_data)  |
                   ({csb_data_w{select_d0}} & d0_rd_data) |
                   ({csb_data_w{select_d1}} & d1_rd_data);

  ////////////////////////////////
  // datapath side
  ////////////////////////////////
  assign op_en_ori = consumer ? grp_op_en[1] : grp_op_en[0];

  // done flushes the line so the next group starts clean
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_pipe <= '0;
    end else if (done) begin
      op_en_pipe <= '0;
    end else begin
      op_en_pipe <= {op_en_pipe[op_en_delay-2:0], op_en_ori};
    end
  end

  assign op_en = op_en_pipe[op_en_delay-1];
  assign cfg   = consumer ? d1_cfg : d0_cfg;  // params follow the consumer

endmodule

/* verilog/pdp_rdma_reg_top.sv */
// pdp rdma register file top
// csb decoder, two ping-pong parameter groups and the launch
// controller; request ready is always high

`timescale 1ns/1ps

module pdp_rdma_reg_top import pdp_rdma_reg_pkg::*; (
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  input  logic      csb_req_pvld,
  input  csb_req_t  csb_req_pd,
  input  logic      dp2reg_done,
  output logic      csb_req_prdy,
  output logic      csb_resp_valid,
  output csb_resp_t csb_resp_pd,
  output rdma_cfg_t reg2dp_cfg,
  output logic      reg2dp_op_en
);

  reg_access_t           access;
  logic [csb_data_w-1:0] rd_data;
  logic [csb_data_w-1:0] d0_rd_data;
  logic [csb_data_w-1:0] d1_rd_data;
  rdma_cfg_t             d0_cfg;
  rdma_cfg_t             d1_cfg;
  logic                  d0_wr_en;
  logic                  d1_wr_en;
  logic                  d0_op_en;
  logic                  d1_op_en;
  logic                  d0_op_en_trigger;
  logic                  d1_op_en_trigger;

  assign csb_req_prdy = 1'b1;  // never back-pressures

  csb_req_decode u_csb (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .req_pvld        (csb_req_pvld),
    .req_pd          (csb_req_pd),
    .rd_data         (rd_data),
    .access          (access),
    .resp_valid      (csb_resp_valid),
    .resp_pd         (csb_resp_pd)
  );

  rdma_reg_group u_group_d0 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .access          (access),
    .wr_en           (d0_wr_en),
    .op_en           (d0_op_en),
    .cfg             (d0_cfg),
    .rd_data         (d0_rd_data),
    .op_en_trigger   (d0_op_en_trigger)
  );

  rdma_reg_group u_group_d1 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .access          (access),
    .wr_en           (d1_wr_en),
    .op_en           (d1_op_en),
    .cfg             (d1_cfg),
    .rd_data         (d1_rd_data),
    .op_en_trigger   (d1_op_en_trigger)
  );

  rdma_launch_ctrl u_launch (
    .nvdla_core_clk   (nvdla_core_clk),
    .nvdla_core_rstn  (nvdla_core_rstn),
    .access           (access),
    .done             (dp2reg_done),
    .d0_cfg           (d0_cfg),
    .d1_cfg           (d1_cfg),
    .d0_rd_data       (d0_rd_data),
    .d1_rd_data       (d1_rd_data),
    .d0_op_en_trigger (d0_op_en_trigger),
    .d1_op_en_trigger (d1_op_en_trigger),
    .d0_wr_en         (d0_wr_en),
    .d1_wr_en         (d1_wr_en),
    .d0_op_en         (d0_op_en),
    .d1_op_en         (d1_op_en),
    .rd_data          (rd_data),
    .cfg              (reg2dp_cfg),
    .op_en            (reg2dp_op_en)
  );

endmodule

/* tb/pdp_rdma_reg_sva.sv */
// csb response and launch timing assertions
// bound to the register file top, checks port behavior only

`timescale 1ns/1ps

module pdp_rdma_reg_sva import pdp_rdma_reg_pkg::*; (
  input logic     nvdla_core_clk,
  input logic     nvdla_core_rstn,
  input logic     csb_req_pvld,
  input csb_req_t csb_req_pd,
  input logic     csb_resp_valid,
  input logic     dp2reg_done,
  input logic     reg2dp_op_en
);

  // response two edges after its request
  a_resp_after_req: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csb_resp_valid |-> $past(csb_req_pvld, 2))
    else $error("csb response without a request two cycles earlier");

  // every read and non-posted write is answered, also back to back
  a_req_gets_resp: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csb_req_pvld && (!csb_req_pd.write || csb_req_pd.nposted) |-> ##2 csb_resp_valid)
    else $error("csb request got no response two cycles later");

  // done flushes the delay line, no launch inside op_en_delay cycles
  a_launch_after_done: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    $rose(reg2dp_op_en) |-> !$past(dp2reg_done, 1) && !$past(dp2reg_done, 2) &&
                            !$past(dp2reg_done, op_en_delay))
    else $error("reg2dp_op_en rose too soon after a done pulse");

endmodule

bind pdp_rdma_reg_top pdp_rdma_reg_sva u_sva (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .csb_req_pvld    (csb_req_pvld),
  .csb_req_pd      (csb_req_pd),
  .csb_resp_valid  (csb_resp_valid),
  .dp2reg_done     (dp2reg_done),
  .reg2dp_op_en    (reg2dp_op_en)
);

/* tb/tb_pdp_rdma_reg.sv */
// pdp rdma register file testbench
// directed tests over csb, requests driven on the falling edge,
// ping-pong programming, launch / done sequence and response kinds

`timescale 1ns/1ps

module tb_pdp_rdma_reg import pdp_rdma_reg_pkg::*;;

  logic      nvdla_core_clk;
  logic      nvdla_core_rstn;
  logic      csb_req_pvld;
  csb_req_t  csb_req_pd;
  logic      dp2reg_done;
  logic      csb_req_prdy;
  logic      csb_resp_valid;
  csb_resp_t csb_resp_pd;
  rdma_cfg_t reg2dp_cfg;
  logic      reg2dp_op_en;

  string                   test_name;
  int                      fail_count;
  logic [csb_data_w-1:0]   grp_vals [2][5];   // programmed fields per group
  logic [reg_offset_w-1:0] field_offs [5];
  logic [csb_data_w-1:0]   field_mask [5];

  pdp_rdma_reg_top UUT (.*);

  always #20 nvdla_core_clk = ~nvdla_core_clk;  // 40 ns

  ////////////////////////////////
  // checking
  ////////////////////////////////
  task automatic report_failure(input string msg);
    fail_count++;
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input logic [95:0] expected, input logic [95:0] actual);
    if (actual !== expected) begin
      report_failure($sformatf("[FAIL] %s expected %0h actual %0h",
                               test_name, expected, actual));
    end
  endtask

  // field set of one group as the datapath should see it
  function automatic rdma_cfg_t expected_cfg(input int grp);
    rdma_cfg_t c;
    c.cube_in_width     = grp_vals[grp][0][dim_w-1:0];
    c.cube_in_height    = grp_vals[grp][1][dim_w-1:0];
    c.cube_in_channel   = grp_vals[grp][2][dim_w-1:0];
    c.src_base_addr_low = grp_vals[grp][3][addr_field_w-1:0];
    c.src_line_stride   = grp_vals[grp][4][addr_field_w-1:0];
    return c;
  endfunction

  ////////////////////////////////
  // bus tasks
  ////////////////////////////////
  task automatic send_req(input logic write, input logic nposted,
                          input logic [reg_offset_w-1:0] offs, input logic [31:0] data);
    @(negedge nvdla_core_clk);
    csb_req_pd         = '0;
    csb_req_pd.addr    = csb_addr_w'(offs >> 2);  // byte offset to word address
    csb_req_pd.wdat    = data;
    csb_req_pd.write   = write;
    csb_req_pd.nposted = nposted;
    csb_req_pd.wrbe    = 4'hf;
    csb_req_pvld       = 1'b1;
    @(negedge nvdla_core_clk);
    csb_req_pvld       = 1'b0;
  endtask

  task automatic wait_response(output csb_resp_t resp);
    bit got;
    got = 1'b0;
    for (int i = 0; i < 20 && !got; i++) begin
      @(negedge nvdla_core_clk);
      if (csb_resp_valid) begin
        got  = 1'b1;
        resp = csb_resp_pd;
      end
    end
    if (!got) report_failure($sformatf("%s: no CSB response within 20 cycles", test_name));
  endtask

  task automatic csb_write(input logic [reg_offset_w-1:0] offs, input logic [31:0] data,
                           input logic nposted);
    csb_resp_t resp;
    send_req(1'b1, nposted, offs, data);
    if (nposted) begin                         // ack carries no data
      wait_response(resp);
      check_value(resp_id_write, resp.kind);
      check_value(0, resp.error);
      check_value(0, resp.rdat);
    end
  endtask

  task automatic csb_read(input logic [reg_offset_w-1:0] offs, output logic [31:0] data);
    csb_resp_t resp;
    send_req(1'b0, 1'b1, offs, '0);
    wait_response(resp);
    check_value(resp_id_read, resp.kind);
    check_value(0, resp.error);
    data = resp.rdat;
  endtask

  task automatic read_expect(input logic [reg_offset_w-1:0] offs, input logic [31:0] expected);
    logic [31:0] data;
    csb_read(offs, data);
    check_value(expected, data);
  endtask

  task automatic expect_no_response(input int cycles);
    repeat (cycles) begin
      @(negedge nvdla_core_clk);
      check_value(0, csb_resp_valid);
    end
  endtask

  task automatic pulse_done();
    @(negedge nvdla_core_clk);
    dp2reg_done = 1'b1;
    @(negedge nvdla_core_clk);
    dp2reg_done = 1'b0;
  endtask

  task automatic wait_op_en(input logic level);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < 20 && !seen; i++) begin
      @(negedge nvdla_core_clk);
      seen = (reg2dp_op_en === level);
    end
    if (!seen) report_failure($sformatf("%s: reg2dp_op_en never reached %0b", test_name, level));
  endtask

  ////////////////////////////////
  // tests
  ////////////////////////////////
  task automatic test_reset_values();
    test_name = "reset_values";
    check_value(1, csb_req_prdy);            // never back-pressures
    read_expect(reg_pointer_offs, 32'h0);
    read_expect(reg_status_offs, 32'h0);
    for (int g = 0; g < 2; g++) begin        // both groups through the producer
      csb_write(reg_pointer_offs, g, 1'b0);
      read_expect(op_enable_offs, 32'h0);
      for (int f = 0; f < 5; f++) read_expect(field_offs[f], 32'h0);
    end
    check_value(0, reg2dp_cfg);
    check_value(0, reg2dp_op_en);
    expect_no_response(8);                   // bus idle, nothing comes back
  endtask

  task automatic test_pingpong_program();
    test_name = "pingpong_program";
    for (int f = 0; f < 5; f++) begin
      grp_vals[0][f] = $urandom & field_mask[f];
      grp_vals[1][f] = $urandom & field_mask[f];
      if (grp_vals[1][f] == grp_vals[0][f]) grp_vals[1][f] ^= 32'h1;
    end
    for (int g = 0; g < 2; g++) begin
      csb_write(reg_pointer_offs, g, 1'b0);
      for (int f = 0; f < 5; f++) csb_write(field_offs[f], grp_vals[g][f], 1'b0);
    end
    for (int g = 0; g < 2; g++) begin
      csb_write(reg_pointer_offs, g, 1'b0);
      for (int f = 0; f < 5; f++) read_expect(field_offs[f], grp_vals[g][f]);
    end
    check_value(expected_cfg(0), reg2dp_cfg);  // consumer still on group 0
  endtask

  task automatic test_launch_and_done();
    test_name = "launch_and_done";
    csb_write(reg_pointer_offs, 32'h0, 1'b0);
    csb_write(op_enable_offs, 32'h1, 1'b0);
    read_expect(reg_status_offs, 32'(status_running));
    wait_op_en(1'b1);
    pulse_done();
    check_value(0, reg2dp_op_en);            // delay line flushed by done
    read_expect(reg_status_offs, 32'h0);
    read_expect(reg_pointer_offs, 32'h0001_0000);
    check_value(expected_cfg(1), reg2dp_cfg);
  endtask

  task automatic test_pending_status();
    test_name = "pending_status";
    // run group 1 once to bring the consumer back to 0
    csb_write(reg_pointer_offs, 32'h1, 1'b0);
    csb_write(op_enable_offs, 32'h1, 1'b0);
    pulse_done();
    read_expect(reg_pointer_offs, 32'h0000_0001);
    csb_write(reg_pointer_offs, 32'h0, 1'b0);
    csb_write(op_enable_offs, 32'h1, 1'b0);
    csb_write(reg_pointer_offs, 32'h1, 1'b0);
    csb_write(op_enable_offs, 32'h1, 1'b0);
    read_expect(reg_status_offs, {14'h0, status_pending, 14'h0, status_running});
  endtask

  task automatic test_busy_write_dropped();
    test_name = "busy_write_dropped";
    csb_write(reg_pointer_offs, 32'h0, 1'b0);
    csb_write(field_offs[0], grp_vals[0][0] ^ 32'h5, 1'b0);  // group 0 armed
    pulse_done();
    read_expect(op_enable_offs, 32'h0);
    read_expect(field_offs[0], grp_vals[0][0]);
  endtask

  task automatic test_response_kinds();
    logic [31:0] height;
    logic [31:0] channel;
    test_name = "response_kinds";
    height  = $urandom & field_mask[1];
    channel = $urandom & field_mask[2];
    if (height == grp_vals[0][1]) height ^= 32'h1;     // must differ from old contents
    if (channel == grp_vals[0][2]) channel ^= 32'h1;
    csb_write(reg_pointer_offs, 32'h0, 1'b0);
    csb_write(field_offs[1], height, 1'b1);  // non-posted, ack checked inside
    send_req(1'b1, 1'b0, field_offs[2], channel);
    expect_no_response(10);                  // posted write stays silent
    read_expect(field_offs[1], height);
    read_expect(field_offs[2], channel);
  endtask

  ////////////////////////////////
  // main sequence
  ////////////////////////////////
  initial begin
    void'($urandom(32'h0eb27489));
    nvdla_core_clk  = 1'b0;
    nvdla_core_rstn = 1'b0;
    csb_req_pvld    = 1'b0;
    csb_req_pd      = '0;
    dp2reg_done     = 1'b0;
    fail_count      = 0;
    field_offs = '{cube_in_width_offs, cube_in_height_offs, cube_in_channel_offs,
                   src_base_addr_low_offs, src_line_stride_offs};
    field_mask = '{32'h1fff, 32'h1fff, 32'h1fff, 32'h07ff_ffff, 32'h07ff_ffff};
    repeat (16) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;

    test_reset_values();
    test_pingpong_program();
    test_launch_and_done();
    test_pending_status();
    test_busy_write_dropped();
    test_response_kinds();

    if (fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
verilog/pdp_rdma_reg_pkg.sv
verilog/csb_req_decode.sv
verilog/rdma_reg_group.sv
verilog/rdma_launch_ctrl.sv
verilog/pdp_rdma_reg_top.sv
tb/pdp_rdma_reg_sva.sv
tb/tb_pdp_rdma_reg.sv

/* Bender.yml */
package:
  name: pdp_rdma_reg

sources:
  - verilog/pdp_rdma_reg_pkg.sv
  - verilog/csb_req_decode.sv
  - verilog/rdma_reg_group.sv
  - verilog/rdma_launch_ctrl.sv
  - verilog/pdp_rdma_reg_top.sv
  - target: test
    files:
      - tb/pdp_rdma_reg_sva.sv
      - tb/tb_pdp_rdma_reg.sv
